//--- hf_core.f
logic/hf_pkg.sv
logic/lsab_bank.sv
logic/block_ram.sv
logic/mvblck_todram.sv
logic/mvblck_frdram.sv
logic/hf_scheduler.sv
logic/hf_core.sv
tb/hf_core_properties.sv
tb/tb_hf_core.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_hf_core
FILELIST = hf_core.f

SOURCES  = $(shell cat $(FILELIST))
BIN      = obj_dir/V$(TOP)
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/tb_hf_core.sv
`timescale 1ns/1ps

module tb_hf_core;

  logic                  CLK_n;
  logic                  RST;
  logic                  i_in_write;
  hf_pkg::word_t         i_in_data;
  hf_pkg::section_t      o_in_slot;
  hf_pkg::section_mask_t o_in_empty;
  logic                  i_out_read;
  hf_pkg::section_t      o_out_slot;
  logic                  o_out_valid;
  hf_pkg::word_t         o_out_data;
  hf_pkg::section_mask_t o_out_full;
  logic                  i_cmd_valid;
  logic                  i_cmd_dir;
  hf_pkg::section_t      i_cmd_section;
  hf_pkg::mem_addr_t     i_cmd_addr;
  hf_pkg::count_t        i_cmd_count;
  logic                  o_busy;
  logic                  o_done;
  hf_pkg::count_t        o_done_count;
  logic                  o_done_abrupt;

  hf_core UUT (.*);

  bind hf_core hf_core_properties u_props (
    .CLK_n(CLK_n), .RST(RST), .i_out_read(i_out_read), .o_out_valid(o_out_valid),
    .o_done(o_done), .o_busy(o_busy)
  );

  // -----------------------------------------------
  // Reference model state
  hf_pkg::word_t     in_q  [hf_pkg::N_SECTIONS][$];
  hf_pkg::word_t     out_q [hf_pkg::N_SECTIONS][$];
  hf_pkg::word_t     mem_m [hf_pkg::MEM_DEPTH];
  bit                mem_ok [hf_pkg::MEM_DEPTH];  // Word has been filled
  hf_pkg::section_t  in_slot_m, out_slot_m;
  bit                active, act_dir;
  hf_pkg::section_t  act_sec;
  hf_pkg::mem_addr_t act_addr;
  hf_pkg::count_t    exp_count;
  bit                exp_abrupt;
  bit                rd_pend, rd_must;
  hf_pkg::section_t  rd_sec;
  int                errors, done_seen, tests_pass, tests_fail, err_base;

  initial
  begin
    CLK_n = 1'b0;
    forever #2 CLK_n = ~CLK_n;
  end

  task automatic value_error(input string name, input longint expv, input longint got);
    $display("CHECK FAILED at %0t: %s expected 0x%0h got 0x%0h", $time, name, expv, got);
    errors++;
  endtask

  // One clock: check what the last edge produced, then drive the next inputs
  task automatic step(input bit wr, input bit rd, input bit cmd, input bit dir,
                      input hf_pkg::section_t sec, input hf_pkg::mem_addr_t addr,
                      input hf_pkg::count_t cnt);
    hf_pkg::word_t     w;
    hf_pkg::mem_addr_t a;
    hf_pkg::section_t  s;
    int                avail;
    @(posedge CLK_n);
    #1;
    in_slot_m++;
    out_slot_m++;
    if (o_in_slot !== in_slot_m)
      value_error("o_in_slot", in_slot_m, o_in_slot);
    if (o_out_slot !== out_slot_m)
      value_error("o_out_slot", out_slot_m, o_out_slot);

    if (rd_pend)
    begin
      if (o_out_valid === 1'b1)
      begin
        if (out_q[rd_sec].size() == 0)
        begin
          $display("Word returned from empty output section %0d at %0t", rd_sec, $time);
          errors++;
        end
        else
        begin
          w = out_q[rd_sec].pop_front();
          if (o_out_data !== w)
            value_error("o_out_data", w, o_out_data);
        end
      end
      else if (rd_must)
        value_error("o_out_valid", 1, o_out_valid);
    end
    rd_pend = 1'b0;

    // -----------------------------------------------
    // Completion report
    if (o_done === 1'b1)
    begin
      done_seen++;
      if (!active)
      begin
        $display("o_done raised with no command running at %0t", $time);
        errors++;
      end
      else
      begin
        if (o_done_count !== exp_count)
          value_error("o_done_count", exp_count, o_done_count);
        if (o_done_abrupt !== exp_abrupt)
          value_error("o_done_abrupt", exp_abrupt, o_done_abrupt);
        if (!act_dir)
          for (int i = 0; i < int'(exp_count); i++)
          begin
            a = act_addr + hf_pkg::mem_addr_t'(i);  // Wraps like the RAM
            mem_m[a]  = in_q[act_sec].pop_front();
            mem_ok[a] = 1'b1;
          end
        active = 1'b0;
      end
    end
    if (o_busy !== active)
      value_error("o_busy", active, o_busy);

    for (int k = 0; k < hf_pkg::N_SECTIONS; k++)
    begin
      if (!(active && !act_dir && act_sec == hf_pkg::section_t'(k)))
        if (o_in_empty[k] !== (in_q[k].size() == 0))
          value_error($sformatf("o_in_empty[%0d]", k), in_q[k].size() == 0, o_in_empty[k]);
      if (!(active && act_dir && act_sec == hf_pkg::section_t'(k)))
        if (o_out_full[k] !== (out_q[k].size() == hf_pkg::SECTION_DEPTH))
          value_error($sformatf("o_out_full[%0d]", k),
                      out_q[k].size() == hf_pkg::SECTION_DEPTH, o_out_full[k]);
    end

    // -----------------------------------------------
    // Next inputs
    i_cmd_valid   = cmd;
    i_cmd_dir     = dir;
    i_cmd_section = sec;
    i_cmd_addr    = addr;
    i_cmd_count   = cnt;
    if (cmd && !active)  // Dropped by the DUT while busy
    begin
      active   = 1'b1;
      act_dir  = dir;
      act_sec  = sec;
      act_addr = addr;
      exp_count  = cnt;
      exp_abrupt = 1'b0;
      if (!dir)
      begin
        avail = in_q[sec].size();
        if (int'(cnt) > avail)
        begin
          exp_count  = hf_pkg::count_t'(avail);
          exp_abrupt = 1'b1;
        end
      end
      else
        for (int i = 0; i < int'(cnt); i++)
          out_q[sec].push_back(mem_m[addr + hf_pkg::mem_addr_t'(i)]);
    end

    i_in_write = 1'b0;
    if (wr)
    begin
      s = o_in_slot;
      if (!(active && !act_dir && s == act_sec) && in_q[s].size() < hf_pkg::SECTION_DEPTH)
      begin
        w          = $urandom;
        i_in_write = 1'b1;
        i_in_data  = w;
        in_q[s].push_back(w);
      end
    end

    i_out_read = rd;
    if (rd)
    begin
      rd_pend = 1'b1;
      rd_sec  = o_out_slot;
      rd_must = (out_q[rd_sec].size() > 0) && !(active && act_dir && rd_sec == act_sec);
    end
  endtask

  task automatic idle(input int n, input bit rd);
    repeat (n) step(1'b0, rd, 1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic issue(input bit dir, input hf_pkg::section_t sec,
                       input hf_pkg::mem_addr_t addr, input hf_pkg::count_t cnt);
    step(1'b0, 1'b0, 1'b1, dir, sec, addr, cnt);
  endtask

  task automatic wait_done(input bit rd, input int limit, input string label);
    int n;
    n = 0;
    while (active && n < limit)
    begin
      step(1'b0, rd, 1'b0, 1'b0, '0, '0, '0);
      n++;
    end
    if (active)
    begin
      $display("Timeout after %0d cycles waiting for o_done in %s", limit, label);
      errors++;
    end
  endtask

  task automatic drain(input int limit, input string label);
    int n;
    int left;
    n    = 0;
    left = 1;
    while (left > 0 && n < limit)
    begin
      step(1'b0, 1'b1, 1'b0, 1'b0, '0, '0, '0);
      left = 0;
      foreach (out_q[k])
        left += out_q[k].size();
      n++;
    end
    if (left > 0)
    begin
      $display("Timeout draining the output buffer in %s, %0d words left", label, left);
      errors++;
    end
  endtask

  task automatic close_test(input string name);
    if (errors == err_base)
    begin
      tests_pass++;
      $display("Test %s: PASS", name);
    end
    else
    begin
      tests_fail++;
      $display("Test %s: FAIL with %0d errors", name, errors - err_base);
    end
    err_base = errors;
  endtask

  // -----------------------------------------------
  // Test sequence
  initial
  begin
    hf_pkg::section_t  sec;
    hf_pkg::section_t  osec;
    hf_pkg::count_t    cnt;
    hf_pkg::mem_addr_t addr;
    bit                wr, rd, cmd, dir;
    int                base;

    void'($urandom(32'hc30));
    RST = 1'b0;
    i_in_write = 1'b0;
    i_in_data = '0;
    i_out_read = 1'b0;
    i_cmd_valid = 1'b0;
    i_cmd_dir = 1'b0;
    i_cmd_section = '0;
    i_cmd_addr = '0;
    i_cmd_count = '0;
    errors = 0;
    done_seen = 0;
    tests_pass = 0;
    tests_fail = 0;
    err_base = 0;

    repeat (10) @(posedge CLK_n);
    #1;
    if (o_in_slot !== 2'd0) value_error("o_in_slot", 0, o_in_slot);
    if (o_out_slot !== 2'd2) value_error("o_out_slot", 2, o_out_slot);
    if (o_busy !== 1'b0) value_error("o_busy", 0, o_busy);
    if (o_done !== 1'b0) value_error("o_done", 0, o_done);
    if (o_in_empty !== 4'hf) value_error("o_in_empty", 4'hf, o_in_empty);
    if (o_out_full !== 4'h0) value_error("o_out_full", 0, o_out_full);
    RST = 1'b1;
    in_slot_m  = hf_pkg::IN_SLOT_RESET;
    out_slot_m = hf_pkg::OUT_SLOT_RESET;
    idle(8, 1'b0);  // Slots checked every cycle
    close_test("reset");

    repeat (40) step(1'b1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    sec = hf_pkg::section_t'($urandom % 4);
    issue(1'b0, sec, 12'h100, hf_pkg::count_t'(in_q[sec].size()));
    wait_done(1'b0, 300, "round trip fill");
    osec = hf_pkg::section_t'($urandom % 4);
    issue(1'b1, osec, 12'h100, exp_count);
    wait_done(1'b1, 500, "round trip empty");
    drain(500, "round trip");
    close_test("round trip");

    repeat (12) step(1'b1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    sec = hf_pkg::section_t'($urandom % 4);
    issue(1'b0, sec, 12'h200, hf_pkg::count_t'(in_q[sec].size() + 5));
    wait_done(1'b0, 300, "abrupt fill");
    idle(1, 1'b0);
    if (o_in_empty[sec] !== 1'b1)
      value_error("o_in_empty[sec]", 1, o_in_empty[sec]);
    close_test("abrupt stop");

    repeat (80) step(1'b1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    issue(1'b0, 2'd0, 12'h300, 6'd16);
    wait_done(1'b0, 300, "back-pressure fill 0");
    issue(1'b0, 2'd1, 12'h310, 6'd16);
    wait_done(1'b0, 300, "back-pressure fill 1");
    issue(1'b1, 2'd3, 12'h300, 6'd30);
    idle(60, 1'b0);
    if (!active)
    begin
      $display("Empty command finished while its section was full at %0t", $time);
      errors++;
    end
    if (o_out_full[3] !== 1'b1)
      value_error("o_out_full[3]", 1, o_out_full[3]);
    wait_done(1'b1, 1000, "back-pressure empty");
    drain(500, "back-pressure");
    close_test("back-pressure");

    repeat (8) step(1'b1, 1'b0, 1'b0, 1'b0, '0, '0, '0);  // Words for the dropped fill
    base = done_seen;
    issue(1'b1, 2'd2, 12'h300, 6'd4);
    issue(1'b0, 2'd0, 12'h000, 6'd5);  // Lands while busy
    wait_done(1'b1, 300, "busy command");
    idle(20, 1'b1);
    drain(300, "busy command");
    if (done_seen - base != 1)
      value_error("o_done pulses", 1, done_seen - base);
    close_test("busy ignore");

    for (int c = 0; c < 4000; c++)
    begin
      wr   = ($urandom % 2) == 0;
      rd   = ($urandom % 3) != 0;
      cmd  = ($urandom % 16) == 0;
      dir  = $urandom % 2;
      sec  = hf_pkg::section_t'($urandom % 4);
      addr = hf_pkg::mem_addr_t'($urandom % 256);
      cnt  = dir ? hf_pkg::count_t'($urandom % 33) : hf_pkg::count_t'($urandom % 21);
      if (cmd && dir)
        for (int i = 0; i < int'(cnt); i++)
          if (!mem_ok[addr + hf_pkg::mem_addr_t'(i)])
            cmd = 1'b0;  // Only read back filled words
      step(wr, rd, cmd, dir, sec, addr, cnt);
    end
    wait_done(1'b1, 2000, "mixed run");
    drain(2000, "mixed run");
    close_test("mixed run");

    $display("Tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- tb/hf_core_properties.sv
`timescale 1ns/1ps

module hf_core_properties (
  input logic CLK_n,
  input logic RST,
  input logic i_out_read,
  input logic o_out_valid,
  input logic o_done,
  input logic o_busy
);

  property done_single_cycle;
    @(posedge CLK_n) disable iff (!RST) o_done |=> !o_done;
  endproperty

  property valid_after_read;
    @(posedge CLK_n) disable iff (!RST) o_out_valid |-> $past(i_out_read);
  endproperty

  property idle_on_done;
    @(posedge CLK_n) disable iff (!RST) o_done |-> !o_busy;
  endproperty

  assert property (done_single_cycle)
    else $error("o_done high for more than one cycle");
  assert property (valid_after_read)
    else $error("o_out_valid without a read one cycle earlier");
  assert property (idle_on_done)
    else $error("o_busy high together with o_done");

endmodule

//--- logic/hf_core.sv
`timescale 1ns/1ps

module hf_core (
  input  logic                  CLK_n,
  input  logic                  RST,
  input  logic                  i_in_write,
  input  hf_pkg::word_t         i_in_data,
  output hf_pkg::section_t      o_in_slot,
  output hf_pkg::section_mask_t o_in_empty,
  input  logic                  i_out_read,
  output hf_pkg::section_t      o_out_slot,
  output logic                  o_out_valid,
  output hf_pkg::word_t         o_out_data,
  output hf_pkg::section_mask_t o_out_full,
  input  logic                  i_cmd_valid,
  input  logic                  i_cmd_dir,
  input  hf_pkg::section_t      i_cmd_section,
  input  hf_pkg::mem_addr_t     i_cmd_addr,
  input  hf_pkg::count_t        i_cmd_count,
  output logic                  o_busy,
  output logic                  o_done,
  output hf_pkg::count_t        o_done_count,
  output logic                  o_done_abrupt
);

  logic              fill_start, empty_start;
  hf_pkg::section_t  cmd_section;
  hf_pkg::mem_addr_t cmd_addr;
  hf_pkg::count_t    cmd_count;
  logic              fill_done, fill_abrupt, empty_done;
  hf_pkg::count_t    fill_count, empty_count;

  logic              fill_read, fill_valid;
  hf_pkg::section_t  fill_section;
  hf_pkg::word_t     fill_data;
  logic              mem_write, mem_read;
  hf_pkg::mem_addr_t mem_waddr, mem_raddr;
  hf_pkg::word_t     mem_wdata, mem_rdata;
  logic              out_write;
  hf_pkg::section_t  out_section;
  hf_pkg::word_t     out_data;

  hf_scheduler u_scheduler (
    .CLK_n(CLK_n), .RST(RST),
    .i_cmd_valid(i_cmd_valid), .i_cmd_dir(i_cmd_dir), .i_cmd_section(i_cmd_section),
    .i_cmd_addr(i_cmd_addr), .i_cmd_count(i_cmd_count),
    .o_busy(o_busy), .o_in_slot(o_in_slot), .o_out_slot(o_out_slot),
    .o_fill_start(fill_start), .o_empty_start(empty_start),
    .o_section(cmd_section), .o_addr(cmd_addr), .o_count(cmd_count),
    .i_fill_done(fill_done), .i_fill_count(fill_count), .i_fill_abrupt(fill_abrupt),
    .i_empty_done(empty_done), .i_empty_count(empty_count),
    .o_done(o_done), .o_done_count(o_done_count), .o_done_abrupt(o_done_abrupt)
  );

  // -----------------------------------------------
  // Input side: external writes, fill mover reads
  lsab_bank lsab_in (
    .CLK_n(CLK_n), .RST(RST),
    .i_write(i_in_write), .i_write_section(o_in_slot), .i_write_data(i_in_data),
    .i_read(fill_read), .i_read_section(fill_section),
    .o_read_valid(fill_valid), .o_read_data(fill_data),
    .o_empty(o_in_empty), .o_full()
  );

  mvblck_todram u_fill (
    .CLK_n(CLK_n), .RST(RST),
    .i_start(fill_start), .i_section(cmd_section), .i_addr(cmd_addr), .i_count(cmd_count),
    .i_empty(o_in_empty),
    .o_lsab_read(fill_read), .o_lsab_section(fill_section),
    .i_lsab_valid(fill_valid), .i_lsab_data(fill_data),
    .o_mem_write(mem_write), .o_mem_addr(mem_waddr), .o_mem_data(mem_wdata),
    .o_done(fill_done), .o_count_sent(fill_count), .o_abrupt(fill_abrupt)
  );

  block_ram u_ram (
    .CLK_n(CLK_n),
    .i_write(mem_write), .i_write_addr(mem_waddr), .i_write_data(mem_wdata),
    .i_read(mem_read), .i_read_addr(mem_raddr), .o_read_data(mem_rdata)
  );

  // -----------------------------------------------
  // Output side: empty mover writes, external reads
  mvblck_frdram u_empty (
    .CLK_n(CLK_n), .RST(RST),
    .i_start(empty_start), .i_section(cmd_section), .i_addr(cmd_addr), .i_count(cmd_count),
    .i_full(o_out_full),
    .o_mem_read(mem_read), .o_mem_addr(mem_raddr), .i_mem_data(mem_rdata),
    .o_lsab_write(out_write), .o_lsab_section(out_section), .o_lsab_data(out_data),
    .o_done(empty_done), .o_count_sent(empty_count)
  );

  lsab_bank lsab_out (
    .CLK_n(CLK_n), .RST(RST),
    .i_write(out_write), .i_write_section(out_section), .i_write_data(out_data),
    .i_read(i_out_read), .i_read_section(o_out_slot),
    .o_read_valid(o_out_valid), .o_read_data(o_out_data),
    .o_empty(), .o_full(o_out_full)
  );

endmodule

//--- logic/hf_scheduler.sv
`timescale 1ns/1ps

module hf_scheduler (
  input  logic              CLK_n,
  input  logic              RST,
  input  logic              i_cmd_valid,
  input  logic              i_cmd_dir,
  input  hf_pkg::section_t  i_cmd_section,
  input  hf_pkg::mem_addr_t i_cmd_addr,
  input  hf_pkg::count_t    i_cmd_count,
  output logic              o_busy,
  output hf_pkg::section_t  o_in_slot,
  output hf_pkg::section_t  o_out_slot,
  output logic              o_fill_start,
  output logic              o_empty_start,
  output hf_pkg::section_t  o_section,
  output hf_pkg::mem_addr_t o_addr,
  output hf_pkg::count_t    o_count,
  input  logic              i_fill_done,
  input  hf_pkg::count_t    i_fill_count,
  input  logic              i_fill_abrupt,
  input  logic              i_empty_done,
  input  hf_pkg::count_t    i_empty_count,
  output logic              o_done,
  output hf_pkg::count_t    o_done_count,
  output logic              o_done_abrupt
);

  logic accept;
  logic mover_done;

  assign accept     = i_cmd_valid && !o_busy;  // Dropped while busy
  assign mover_done = i_fill_done || i_empty_done;

  // Command fields for the movers
  always_ff @(posedge CLK_n)
  begin
    if (accept)
    begin
      o_section <= i_cmd_section;
      o_addr    <= i_cmd_addr;
      o_count   <= i_cmd_count;
    end
  end

  // -----------------------------------------------
  // Slots, dispatch and completion
  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      o_in_slot     <= hf_pkg::IN_SLOT_RESET;
      o_out_slot    <= hf_pkg::OUT_SLOT_RESET;
      o_busy        <= 1'b0;
      o_fill_start  <= 1'b0;
      o_empty_start <= 1'b0;
      o_done        <= 1'b0;
      o_done_count  <= '0;
      o_done_abrupt <= 1'b0;
    end
    else
    begin
      o_in_slot     <= o_in_slot + 1'b1;  // Wraps at 4
      o_out_slot    <= o_out_slot + 1'b1;
      o_fill_start  <= accept && !i_cmd_dir;
      o_empty_start <= accept && i_cmd_dir;
      o_done        <= mover_done;

      if (accept)
        o_busy <= 1'b1;
      else if (mover_done)
        o_busy <= 1'b0;

      if (i_fill_done)
      begin
        o_done_count  <= i_fill_count;
        o_done_abrupt <= i_fill_abrupt;
      end
      else if (i_empty_done)
      begin
        o_done_count  <= i_empty_count;
        o_done_abrupt <= 1'b0;   // Empty side always finishes
      end
    end
  end

endmodule

//--- logic/mvblck_frdram.sv
`timescale 1ns/1ps

module mvblck_frdram (
  input  logic                  CLK_n,
  input  logic                  RST,
  input  logic                  i_start,
  input  hf_pkg::section_t      i_section,
  input  hf_pkg::mem_addr_t     i_addr,
  input  hf_pkg::count_t        i_count,
  input  hf_pkg::section_mask_t i_full,
  output logic                  o_mem_read,
  output hf_pkg::mem_addr_t     o_mem_addr,
  input  hf_pkg::word_t         i_mem_data,
  output logic                  o_lsab_write,
  output hf_pkg::section_t      o_lsab_section,
  output hf_pkg::word_t         o_lsab_data,
  output logic                  o_done,
  output hf_pkg::count_t        o_count_sent
);

  logic              running;
  logic              word_ready;  // i_mem_data holds the next word
  logic              finished;
  hf_pkg::section_t  section_q;
  hf_pkg::mem_addr_t addr_q;
  hf_pkg::count_t    count_q;
  hf_pkg::count_t    fetched;
  hf_pkg::count_t    written;

  // A full section stalls the write and with it the next fetch
  assign o_lsab_write   = running && word_ready && !i_full[section_q];
  assign o_lsab_section = section_q;
  assign o_lsab_data    = i_mem_data;
  assign o_mem_read     = running && (fetched != count_q) && (!word_ready || o_lsab_write);
  assign o_mem_addr     = addr_q + hf_pkg::mem_addr_t'(fetched);

  assign finished = running && (written == count_q);

  always_ff @(posedge CLK_n)
  begin
    if (i_start && !running)
    begin
      section_q <= i_section;
      addr_q    <= i_addr;
      count_q   <= i_count;
    end
  end

  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      running      <= 1'b0;
      word_ready   <= 1'b0;
      fetched      <= '0;
      written      <= '0;
      o_done       <= 1'b0;
      o_count_sent <= '0;
    end
    else
    begin
      o_done <= 1'b0;
      if (i_start && !running)
      begin
        running    <= 1'b1;
        word_ready <= 1'b0;
        fetched    <= '0;
        written    <= '0;
      end
      else if (running)
      begin
        if (o_mem_read)
          fetched <= fetched + 1'b1;
        if (o_lsab_write)
          written <= written + 1'b1;

        if (o_mem_read)
          word_ready <= 1'b1;
        else if (o_lsab_write)
          word_ready <= 1'b0;

        if (finished)
        begin
          running      <= 1'b0;
          o_done       <= 1'b1;
          o_count_sent <= written;
        end
      end
    end
  end

endmodule

//--- logic/mvblck_todram.sv
`timescale 1ns/1ps

module mvblck_todram (
  input  logic                  CLK_n,
  input  logic                  RST,
  input  logic                  i_start,
  input  hf_pkg::section_t      i_section,
  input  hf_pkg::mem_addr_t     i_addr,
  input  hf_pkg::count_t        i_count,
  input  hf_pkg::section_mask_t i_empty,
  output logic                  o_lsab_read,
  output hf_pkg::section_t      o_lsab_section,
  input  logic                  i_lsab_valid,
  input  hf_pkg::word_t         i_lsab_data,
  output logic                  o_mem_write,
  output hf_pkg::mem_addr_t     o_mem_addr,
  output hf_pkg::word_t         o_mem_data,
  output logic                  o_done,
  output hf_pkg::count_t        o_count_sent,
  output logic                  o_abrupt
);

  logic              running;
  logic              pending;   // Read issued last cycle
  logic              finished;
  hf_pkg::section_t  section_q;
  hf_pkg::mem_addr_t addr_q;
  hf_pkg::count_t    count_q;
  hf_pkg::count_t    issued;
  hf_pkg::count_t    stored;

  assign o_lsab_section = section_q;
  assign o_lsab_read    = running && (issued != count_q) && !i_empty[section_q];
  assign o_mem_write    = running && i_lsab_valid;
  assign o_mem_addr     = addr_q + hf_pkg::mem_addr_t'(stored);  // Wraps
  assign o_mem_data     = i_lsab_data;

  // Full count reached, or section dry with nothing in flight
  assign finished = running && !pending && ((issued == count_q) || i_empty[section_q]);

  always_ff @(posedge CLK_n)
  begin
    if (i_start && !running)
    begin
      section_q <= i_section;
      addr_q    <= i_addr;
      count_q   <= i_count;
    end
  end

  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      running      <= 1'b0;
      pending      <= 1'b0;
      issued       <= '0;
      stored       <= '0;
      o_done       <= 1'b0;
      o_count_sent <= '0;
      o_abrupt     <= 1'b0;
    end
    else
    begin
      o_done  <= 1'b0;
      pending <= o_lsab_read;
      if (i_start && !running)
      begin
        running <= 1'b1;
        issued  <= '0;
        stored  <= '0;
      end
      else if (running)
      begin
        if (o_lsab_read)
          issued <= issued + 1'b1;
        if (i_lsab_valid)
          stored <= stored + 1'b1;
        if (finished)
        begin
          running      <= 1'b0;
          o_done       <= 1'b1;
          o_count_sent <= issued;
          o_abrupt     <= (issued != count_q);
        end
      end
    end
  end

endmodule

//--- logic/block_ram.sv
`timescale 1ns/1ps

module block_ram (
  input  logic              CLK_n,
  input  logic              i_write,
  input  hf_pkg::mem_addr_t i_write_addr,
  input  hf_pkg::word_t     i_write_data,
  input  logic              i_read,
  input  hf_pkg::mem_addr_t i_read_addr,
  output hf_pkg::word_t     o_read_data
);

  hf_pkg::word_t mem [hf_pkg::MEM_DEPTH];

  always_ff @(posedge CLK_n)
  begin
    if (i_write)
      mem[i_write_addr] <= i_write_data;
  end

  // Output register keeps its word while no read is issued
  always_ff @(posedge CLK_n)
  begin
    if (i_read)
      o_read_data <= mem[i_read_addr];
  end

endmodule

//--- logic/lsab_bank.sv
`timescale 1ns/1ps

module lsab_bank (
  input  logic                  CLK_n,
  input  logic                  RST,
  input  logic                  i_write,
  input  hf_pkg::section_t      i_write_section,
  input  hf_pkg::word_t         i_write_data,
  input  logic                  i_read,
  input  hf_pkg::section_t      i_read_section,
  output logic                  o_read_valid,
  output hf_pkg::word_t         o_read_data,
  output hf_pkg::section_mask_t o_empty,
  output hf_pkg::section_mask_t o_full
);

  hf_pkg::word_t                     storage [hf_pkg::N_SECTIONS*hf_pkg::SECTION_DEPTH];
  logic [hf_pkg::SECTION_PTR_W-1:0]  head [hf_pkg::N_SECTIONS];
  logic [hf_pkg::SECTION_PTR_W-1:0]  tail [hf_pkg::N_SECTIONS];
  logic [hf_pkg::SECTION_FILL_W-1:0] fill [hf_pkg::N_SECTIONS];
  logic [hf_pkg::SECTION_FILL_W-1:0] fill_next [hf_pkg::N_SECTIONS];
  hf_pkg::section_mask_t             wr_hit;
  hf_pkg::section_mask_t             rd_hit;
  logic                              wr_ok;
  logic                              rd_ok;
  logic [hf_pkg::BANK_INDEX_W-1:0]   wr_index;
  logic [hf_pkg::BANK_INDEX_W-1:0]   rd_index;

  assign wr_ok    = i_write && !o_full[i_write_section];   // Lost when full
  assign rd_ok    = i_read && !o_empty[i_read_section];
  assign wr_index = {i_write_section, tail[i_write_section]};
  assign rd_index = {i_read_section, head[i_read_section]};

  always_comb
  begin
    for (int s = 0; s < hf_pkg::N_SECTIONS; s++)
    begin
      wr_hit[s]    = wr_ok && (i_write_section == hf_pkg::section_t'(s));
      rd_hit[s]    = rd_ok && (i_read_section == hf_pkg::section_t'(s));
      fill_next[s] = fill[s];
      if (wr_hit[s] && !rd_hit[s])
        fill_next[s] = fill[s] + 1'b1;
      else if (rd_hit[s] && !wr_hit[s])
        fill_next[s] = fill[s] - 1'b1;
    end
  end

  // -----------------------------------------------
  // Word storage
  always_ff @(posedge CLK_n)
  begin
    if (wr_ok)
      storage[wr_index] <= i_write_data;
    if (rd_ok)
      o_read_data <= storage[rd_index];  // Oldest word of the section
  end

  // -----------------------------------------------
  // Per-section pointers and flags
  always_ff @(posedge CLK_n)
  begin
    if (!RST)
    begin
      o_read_valid <= 1'b0;
      o_empty      <= '1;
      o_full       <= '0;
      for (int s = 0; s < hf_pkg::N_SECTIONS; s++)
      begin
        head[s] <= '0;
        tail[s] <= '0;
        fill[s] <= '0;
      end
    end
    else
    begin
      o_read_valid <= rd_ok;
      for (int s = 0; s < hf_pkg::N_SECTIONS; s++)
      begin
        if (wr_hit[s])
          tail[s] <= tail[s] + 1'b1;
        if (rd_hit[s])
          head[s] <= head[s] + 1'b1;
        fill[s]    <= fill_next[s];
        o_empty[s] <= (fill_next[s] == '0);
        o_full[s]  <= (fill_next[s] == hf_pkg::SECTION_FILL_FULL);
      end
    end
  end

endmodule

//--- logic/hf_pkg.sv
package hf_pkg;

  localparam int N_SECTIONS     = 4;
  localparam int SECTION_W      = 2;
  localparam int WORD_W         = 32;
  localparam int SECTION_DEPTH  = 16;
  localparam int SECTION_PTR_W  = 4;
  localparam int SECTION_FILL_W = 5;  // Holds 0 to SECTION_DEPTH
  localparam int BANK_INDEX_W   = SECTION_W + SECTION_PTR_W;
  localparam int MEM_ADDR_W     = 12;
  localparam int MEM_DEPTH      = 4096;
  localparam int COUNT_W        = 6;

  typedef logic [WORD_W-1:0]     word_t;
  typedef logic [SECTION_W-1:0]  section_t;
  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [COUNT_W-1:0]    count_t;
  typedef logic [N_SECTIONS-1:0] section_mask_t;

  localparam logic [SECTION_FILL_W-1:0] SECTION_FILL_FULL = SECTION_FILL_W'(SECTION_DEPTH);

  // Slot rotation start points
  localparam section_t IN_SLOT_RESET  = 2'd0;
  localparam section_t OUT_SLOT_RESET = 2'd2;

endpackage
